// ==== led_panel_ctrl.f ====
+incdir+.
ctrl_pkg.sv
cmd_unit_if.sv
cmd_decoder.sv
panel_sweeper.sv
pixel_writer.sv
led_panel_ctrl.sv
tb_led_panel_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f led_panel_ctrl.f \
    --top-module tb_led_panel_ctrl -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if grep -q "ALL TESTS PASSED" <<< "$output"; then
    exit 0
fi
exit 1

// ==== tb_panel_model.svh ====
/*
 * reference model of the colour and brightness registers and frame RAM,
 * LCG random source
 */
`ifndef TB_PANEL_MODEL_SVH
`define TB_PANEL_MODEL_SVH

localparam int m_levels = ctrl_pkg::default_brightness_levels;
localparam int m_row_bits = ctrl_pkg::default_row_bits;
localparam int m_col_bits = ctrl_pkg::default_col_bits;
localparam int m_addr_bits = m_row_bits + m_col_bits + 1;
localparam int m_ram_size = 1 << m_addr_bits;

logic [31:0] rand_state = 32'hd628;
logic [2:0] m_rgb;
logic [m_levels-1:0] m_bright;
logic [7:0] m_ram [m_ram_size];

function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
endfunction

// low LCG bits repeat quickly, take the upper half
function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:16]) % n;
endfunction

// colour and brightness groups only
function automatic void apply_single(input logic [7:0] b);
    int arg;
    arg = int'(b[3:0]);
    if (b[7:4] == ctrl_pkg::grp_colour && b[2:1] != 2'd3) begin
        m_rgb[b[2:1]] = b[0];
    end else if (b[7:4] == ctrl_pkg::grp_bright) begin
        if (arg == 0) begin
            m_bright = '0;
        end else if (arg == 9) begin
            m_bright = '1;
        end else if (arg <= m_levels) begin
            m_bright[m_levels - arg] = ~m_bright[m_levels - arg];
        end
    end
endfunction

function automatic void apply_fill(input logic [7:0] lo, input logic [7:0] hi);
    for (int i = 0; i < m_ram_size; i++) begin
        m_ram[i] = (i % 2 == 1) ? hi : lo;
    end
endfunction

function automatic void apply_pixel(input logic [7:0] row, input logic [7:0] col,
                                    input logic [7:0] lo, input logic [7:0] hi);
    m_ram[{row[m_row_bits-1:0], col[m_col_bits-1:0], 1'b0}] = lo;
    m_ram[{row[m_row_bits-1:0], col[m_col_bits-1:0], 1'b1}] = hi;
endfunction

`endif

// ==== tb_led_panel_ctrl.sv ====
/*
 * testbench for the LED panel controller: random opcodes, readbright,
 * fill and blank sweeps, pixel writes
 */
`timescale 1ns/1ns

module tb_led_panel_ctrl;

    `include "tb_panel_model.svh"

    // the whole run needs under 2000 cycles
    localparam int max_cycles = 20000;

    logic clk_in = 1'b0;
    logic reset;
    logic [7:0] data;
    logic data_valid;
    logic ready;
    logic busy;
    logic [2:0] rgb_enable;
    logic [m_levels-1:0] brightness_enable;
    logic ram_we;
    logic [m_addr_bits-1:0] ram_addr;
    logic [7:0] ram_wdata;

    logic [7:0] shadow [m_ram_size];
    int write_count = 0;
    int cycle_count = 0;
    int errors = 0;

    led_panel_ctrl dut_i (
        .clk_in(clk_in),
        .reset(reset),
        .data(data),
        .data_valid(data_valid),
        .ready(ready),
        .busy(busy),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable),
        .ram_we(ram_we),
        .ram_addr(ram_addr),
        .ram_wdata(ram_wdata)
    );

    always #5 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
    end

    // odd multiplier, so every address gets its own byte
    function automatic logic [7:0] fill_pattern(input int i);
        return 8'(i * 37 + 27);
    endfunction

    // external frame RAM as seen on the write port
    always @(posedge clk_in) begin
        if (reset) begin
            for (int i = 0; i < m_ram_size; i++) begin
                shadow[i] <= fill_pattern(i);
            end
        end else if (ram_we) begin
            shadow[ram_addr] <= ram_wdata;
            write_count <= write_count + 1;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic send_byte(input logic [7:0] b, input int gap);
        repeat (gap) @(negedge clk_in);
        data = b;
        data_valid = 1'b1;
        while (!ready) @(negedge clk_in);
        @(posedge clk_in);
        @(negedge clk_in);
        data_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (busy) @(negedge clk_in);
    endtask

    task automatic compare_ram();
        for (int i = 0; i < m_ram_size; i++) begin
            check($sformatf("ram[%0h]", i), 32'(shadow[i]), 32'(m_ram[i]));
        end
    endtask

    // mostly colour and brightness, some unused groups
    function automatic logic [7:0] random_opcode();
        int sel;
        logic [3:0] grp;
        sel = rand_below(8);
        if (sel < 3) grp = ctrl_pkg::grp_colour;
        else if (sel < 6) grp = ctrl_pkg::grp_bright;
        else if (sel == 6) grp = 4'd0;
        else grp = 4'(4 + rand_below(12));
        return {grp, 4'(rand_below(16))};
    endfunction

    task automatic run_sweep(input logic blank);
        logic [7:0] lo;
        logic [7:0] hi;
        int start_count;
        lo = 8'h00;
        hi = 8'h00;
        start_count = write_count;
        if (blank) begin
            send_byte({ctrl_pkg::grp_multi, ctrl_pkg::multi_blank}, 0);
        end else begin
            lo = 8'(rand_below(256));
            hi = 8'(rand_below(256));
            send_byte({ctrl_pkg::grp_multi, ctrl_pkg::multi_fill}, 0);
            send_byte(lo, 0);
            send_byte(hi, 0);
        end
        wait_idle();
        apply_fill(lo, hi);
        compare_ram();
        check("sweep write count", write_count - start_count, m_ram_size);
    endtask

    task automatic run_pixel();
        logic [7:0] row;
        logic [7:0] col;
        logic [7:0] lo;
        logic [7:0] hi;
        int start_count;
        row = 8'(rand_below(256));
        col = 8'(rand_below(256));
        lo = 8'(rand_below(256));
        hi = 8'(rand_below(256));
        start_count = write_count;
        send_byte({ctrl_pkg::grp_multi, ctrl_pkg::multi_pixel}, rand_below(3));
        send_byte(row, rand_below(3));
        send_byte(col, rand_below(3));
        send_byte(lo, rand_below(3));
        send_byte(hi, rand_below(3));
        wait_idle();
        apply_pixel(row, col, lo, hi);
        compare_ram();
        check("pixel write count", write_count - start_count, 2);
    endtask

    initial begin
        logic [7:0] b;
        reset = 1'b1;
        data = 8'h00;
        data_valid = 1'b0;
        m_rgb = 3'b111;
        m_bright = '1;
        for (int i = 0; i < m_ram_size; i++) begin
            m_ram[i] = fill_pattern(i);
        end
        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;

        check("rgb_enable", rgb_enable, 3'b111);
        check("brightness_enable", brightness_enable, {m_levels{1'b1}});
        check("busy", busy, 1'b0);
        check("ready", ready, 1'b1);

        for (int n = 0; n < 200; n++) begin
            b = random_opcode();
            send_byte(b, 0);
            apply_single(b);
            @(negedge clk_in);
            check("rgb_enable", rgb_enable, m_rgb);
            check("brightness_enable", brightness_enable, m_bright);
        end

        b = 8'(rand_below(256));
        send_byte({ctrl_pkg::grp_multi, ctrl_pkg::multi_readbright}, 0);
        send_byte(b, 0);
        wait_idle();
        m_bright = b[m_levels-1:0];
        check("brightness_enable", brightness_enable, m_bright);

        run_sweep(1'b0);
        run_sweep(1'b1);
        for (int n = 0; n < 30; n++) begin
            run_pixel();
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        wait (cycle_count >= max_cycles);
        $display("timeout: the run did not finish within %0d clock cycles", max_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== led_panel_ctrl.sv ====
/*
 * LED panel command controller top: decoder, sweeper, pixel writer
 */
`timescale 1ns/1ns

module led_panel_ctrl #(
    parameter int row_bits = ctrl_pkg::default_row_bits,
    parameter int col_bits = ctrl_pkg::default_col_bits,
    parameter int brightness_levels = ctrl_pkg::default_brightness_levels
) (
    input logic clk_in,
    input logic reset,
    input logic [7:0] data,
    input logic data_valid,
    output logic ready,
    output logic busy,
    output logic [2:0] rgb_enable,
    output logic [brightness_levels-1:0] brightness_enable,
    output logic ram_we,
    output logic [row_bits+col_bits:0] ram_addr,
    output logic [7:0] ram_wdata
);

    logic sweep_blank;

    cmd_unit_if #(.addr_bits(row_bits + col_bits + 1)) sweep_if ();
    cmd_unit_if #(.addr_bits(row_bits + col_bits + 1)) pixel_if ();

    cmd_decoder #(
        .row_bits(row_bits),
        .col_bits(col_bits),
        .brightness_levels(brightness_levels)
    ) decoder_i (
        .clk_in(clk_in),
        .reset(reset),
        .data(data),
        .data_valid(data_valid),
        .ready(ready),
        .busy(busy),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable),
        .ram_we(ram_we),
        .ram_addr(ram_addr),
        .ram_wdata(ram_wdata),
        .sweep_blank(sweep_blank),
        .sweep(sweep_if.ctrl),
        .pixel(pixel_if.ctrl)
    );

    panel_sweeper #(
        .row_bits(row_bits),
        .col_bits(col_bits)
    ) sweeper_i (
        .clk_in(clk_in),
        .reset(reset),
        .blank(sweep_blank),
        .unit(sweep_if.unit)
    );

    pixel_writer #(
        .row_bits(row_bits),
        .col_bits(col_bits)
    ) pixel_i (
        .clk_in(clk_in),
        .reset(reset),
        .unit(pixel_if.unit)
    );

endmodule

// ==== pixel_writer.sv ====
/*
 * single pixel write unit: row, column and two colour bytes
 */
`timescale 1ns/1ns

module pixel_writer #(
    parameter int row_bits = 3,
    parameter int col_bits = 3
) (
    input logic clk_in,
    input logic reset,
    cmd_unit_if.unit unit
);

    typedef enum logic [1:0] {
        px_idle,
        px_args,
        px_wr_lo,
        px_wr_hi
    } state_t;

    state_t state;
    logic [1:0] arg_cnt;
    logic [row_bits-1:0] row;
    logic [col_bits-1:0] col;
    logic [7:0] colour_lo;
    logic [7:0] colour_hi;
    logic writing;

    assign writing = (state == px_wr_lo) || (state == px_wr_hi);

    assign unit.arg_ready = (state == px_args);
    assign unit.we = writing;
    assign unit.addr = {row, col, (state == px_wr_hi)};
    assign unit.wdata = (state == px_wr_hi) ? colour_hi : colour_lo;
    assign unit.done = (state == px_wr_hi);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= px_idle;
            arg_cnt <= 2'd0;
        end else begin
            case (state)
                px_idle: begin
                    arg_cnt <= 2'd0;
                    if (unit.start) begin
                        state <= px_args;
                    end
                end
                px_args: begin
                    if (unit.arg_valid) begin
                        arg_cnt <= arg_cnt + 2'd1;
                        if (arg_cnt == 2'd3) begin
                            state <= px_wr_lo;
                        end
                    end
                end
                px_wr_lo: state <= px_wr_hi;
                px_wr_hi: state <= px_idle;
                default: state <= px_idle;
            endcase
        end
    end

    // row, column, then colour bytes
    always_ff @(posedge clk_in) begin
        if (state == px_args && unit.arg_valid) begin
            case (arg_cnt)
                2'd0: row <= unit.arg_data[row_bits-1:0];
                2'd1: col <= unit.arg_data[col_bits-1:0];
                2'd2: colour_lo <= unit.arg_data;
                default: colour_hi <= unit.arg_data;
            endcase
        end
    end

    a_no_arg_in_write: assert property (
        @(posedge clk_in) disable iff (reset) writing |-> !unit.arg_valid
    );

endmodule

// ==== panel_sweeper.sv ====
/*
 * blank and fill unit, writes the whole frame RAM in order
 */
`timescale 1ns/1ns

module panel_sweeper #(
    parameter int row_bits = 3,
    parameter int col_bits = 3
) (
    input logic clk_in,
    input logic reset,
    input logic blank,
    cmd_unit_if.unit unit
);

    localparam int addr_bits = row_bits + col_bits + 1;

    typedef enum logic [1:0] {
        sw_idle,
        sw_args,
        sw_run
    } state_t;

    state_t state;
    logic second_arg;
    logic [addr_bits-1:0] addr_cnt;
    logic [7:0] colour_lo;
    logic [7:0] colour_hi;

    assign unit.arg_ready = (state == sw_args);
    assign unit.we = (state == sw_run);
    assign unit.addr = addr_cnt;
    // odd byte select takes the second colour byte
    assign unit.wdata = addr_cnt[0] ? colour_hi : colour_lo;
    assign unit.done = (state == sw_run) && (&addr_cnt);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= sw_idle;
            second_arg <= 1'b0;
            addr_cnt <= '0;
        end else begin
            case (state)
                sw_idle: begin
                    addr_cnt <= '0;
                    second_arg <= 1'b0;
                    if (unit.start) begin
                        state <= blank ? sw_run : sw_args;
                    end
                end
                sw_args: begin
                    if (unit.arg_valid) begin
                        second_arg <= 1'b1;
                        if (second_arg) begin
                            state <= sw_run;
                        end
                    end
                end
                sw_run: begin
                    addr_cnt <= addr_cnt + 1'b1;
                    if (unit.done) begin
                        state <= sw_idle;
                    end
                end
                default: state <= sw_idle;
            endcase
        end
    end

    // colour bytes, cleared for blank
    always_ff @(posedge clk_in) begin
        if (state == sw_idle && unit.start && blank) begin
            colour_lo <= 8'h00;
            colour_hi <= 8'h00;
        end else if (state == sw_args && unit.arg_valid) begin
            if (second_arg) begin
                colour_hi <= unit.arg_data;
            end else begin
                colour_lo <= unit.arg_data;
            end
        end
    end

    a_no_restart: assert property (
        @(posedge clk_in) disable iff (reset) unit.start |-> (state == sw_idle)
    );

endmodule

// ==== cmd_decoder.sv ====
/*
 * opcode decoder with colour and brightness registers,
 * argument routing to the units and RAM write mux
 */
`timescale 1ns/1ns

module cmd_decoder #(
    parameter int row_bits = 3,
    parameter int col_bits = 3,
    parameter int brightness_levels = 6
) (
    input logic clk_in,
    input logic reset,
    input ctrl_pkg::cmd_byte_u data,
    input logic data_valid,
    output logic ready,
    output logic busy,
    output logic [2:0] rgb_enable,
    output logic [brightness_levels-1:0] brightness_enable,
    output logic ram_we,
    output logic [row_bits+col_bits:0] ram_addr,
    output logic [7:0] ram_wdata,
    output logic sweep_blank,
    cmd_unit_if.ctrl sweep,
    cmd_unit_if.ctrl pixel
);

    typedef enum logic [1:0] {
        st_idle,
        st_readbright,
        st_sweep,
        st_pixel
    } state_t;

    state_t state;
    logic accept;
    logic sweep_start;
    logic pixel_start;

    assign accept = data_valid && ready;
    assign busy = (state != st_idle);

    assign sweep.start = sweep_start;
    assign sweep.arg_data = data.raw;
    assign sweep.arg_valid = data_valid && sweep.arg_ready && (state == st_sweep);

    assign pixel.start = pixel_start;
    assign pixel.arg_data = data.raw;
    assign pixel.arg_valid = data_valid && pixel.arg_ready && (state == st_pixel);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= st_idle;
            rgb_enable <= 3'b111;
            brightness_enable <= '1;
            sweep_start <= 1'b0;
            pixel_start <= 1'b0;
        end else begin
            sweep_start <= 1'b0;
            pixel_start <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        case (data.fields.group)
                            ctrl_pkg::grp_colour: begin
                                if (data.fields.arg[2:1] != ctrl_pkg::chan_ignored) begin
                                    rgb_enable[data.fields.arg[2:1]] <= data.fields.arg[0];
                                end
                            end
                            ctrl_pkg::grp_bright: begin
                                if (data.fields.arg == ctrl_pkg::bright_zero) begin
                                    brightness_enable <= '0;
                                end else if (data.fields.arg == ctrl_pkg::bright_all) begin
                                    brightness_enable <= '1;
                                end else if (int'(data.fields.arg) <= brightness_levels) begin
                                    // arg 1 is the top bit
                                    brightness_enable[brightness_levels - data.fields.arg] <=
                                        ~brightness_enable[brightness_levels - data.fields.arg];
                                end
                            end
                            ctrl_pkg::grp_multi: begin
                                case (data.fields.arg)
                                    ctrl_pkg::multi_readbright: state <= st_readbright;
                                    ctrl_pkg::multi_blank, ctrl_pkg::multi_fill: begin
                                        state <= st_sweep;
                                        sweep_start <= 1'b1;
                                    end
                                    ctrl_pkg::multi_pixel: begin
                                        state <= st_pixel;
                                        pixel_start <= 1'b1;
                                    end
                                    default: ;
                                endcase
                            end
                            default: ;
                        endcase
                    end
                end
                st_readbright: begin
                    if (accept) begin
                        brightness_enable <= data.raw[brightness_levels-1:0];
                        state <= st_idle;
                    end
                end
                st_sweep: begin
                    if (sweep.done) begin
                        state <= st_idle;
                    end
                end
                st_pixel: begin
                    if (pixel.done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // mode for the sweeper to latch on start
    always_ff @(posedge clk_in) begin
        if (state == st_idle && accept) begin
            sweep_blank <= (data.fields.arg == ctrl_pkg::multi_blank);
        end
    end

    always_comb begin
        ready = 1'b1;
        ram_we = 1'b0;
        ram_addr = '0;
        ram_wdata = 8'h00;
        case (state)
            st_sweep: begin
                ready = sweep.arg_ready;
                ram_we = sweep.we;
                ram_addr = sweep.addr;
                ram_wdata = sweep.wdata;
            end
            st_pixel: begin
                ready = pixel.arg_ready;
                ram_we = pixel.we;
                ram_addr = pixel.addr;
                ram_wdata = pixel.wdata;
            end
            default: ;
        endcase
    end

    a_we_only_busy: assert property (
        @(posedge clk_in) disable iff (reset) (sweep.we || pixel.we) |-> busy
    );

    a_one_writer: assert property (
        @(posedge clk_in) disable iff (reset) !(sweep.we && pixel.we)
    );

endmodule

// ==== cmd_unit_if.sv ====
/*
 * decoder to command unit link: start, argument bytes,
 * RAM write and done
 */
`timescale 1ns/1ns

interface cmd_unit_if #(
    parameter int addr_bits = 7
);
    logic start;
    logic arg_valid;
    logic [7:0] arg_data;
    logic arg_ready;
    logic we;
    logic [addr_bits-1:0] addr;
    logic [7:0] wdata;
    logic done;

    modport ctrl (
        output start,
        output arg_valid,
        output arg_data,
        input arg_ready,
        input we,
        input addr,
        input wdata,
        input done
    );

    modport unit (
        input start,
        input arg_valid,
        input arg_data,
        output arg_ready,
        output we,
        output addr,
        output wdata,
        output done
    );

endinterface

// ==== ctrl_pkg.sv ====
/*
 * opcode groups and arguments, command byte union,
 * default panel and brightness sizes
 */
package ctrl_pkg;

    // default panel geometry
    localparam int default_row_bits = 3;
    localparam int default_col_bits = 3;
    localparam int default_brightness_levels = 6;

    // opcode groups, anything else is dropped
    localparam logic [3:0] grp_colour = 4'd1;
    localparam logic [3:0] grp_bright = 4'd2;
    localparam logic [3:0] grp_multi = 4'd3;

    // colour group: arg[0] enable, arg[2:1] channel
    localparam logic [1:0] chan_ignored = 2'd3;

    // brightness group, 1..levels toggles bit (levels - arg)
    localparam logic [3:0] bright_zero = 4'd0;
    localparam logic [3:0] bright_all = 4'd9;

    // multi-byte commands
    localparam logic [3:0] multi_readbright = 4'd0;
    localparam logic [3:0] multi_blank = 4'd1;
    localparam logic [3:0] multi_fill = 4'd2;
    localparam logic [3:0] multi_pixel = 4'd3;

    typedef struct packed {
        logic [3:0] group;
        logic [3:0] arg;
    } cmd_fields_t;

    // decoder reads fields, units read raw
    typedef union packed {
        logic [7:0] raw;
        cmd_fields_t fields;
    } cmd_byte_u;

endpackage
